/* hw/cu_defs.svh */
/* Widths and field positions of the fixed 16-bit instruction format
   {opcode, reg1, reg2, imm6}; changing them breaks the opcode table */
`ifndef CU_DEFS_SVH
`define CU_DEFS_SVH

// Instruction word
`define CU_INSTR_W 16

// Field widths
`define CU_OPC_W   4    // Opcode
`define CU_REG_W   3    // Register address, eight registers
`define CU_IMM6_W  6    // Raw immediate as encoded

// Field positions, counted from bit 0
`define CU_OPC_LSB  12
`define CU_REG1_LSB 9
`define CU_REG2_LSB 6

// Datapath side
`define CU_DATA_W  8    // Data bus and zero-extended immediate
`define CU_ALUOP_W 4    // ALU operation select

`endif

/* hw/cu_pkg.sv */
/* Shared types of the control unit; widths come from cu_defs.svh.
   Opcode 1111 is NOT, or HALT when all other fields are zero */
`include "cu_defs.svh"

package cu_pkg;

    typedef logic [`CU_INSTR_W-1:0] instr_t;     // Full instruction word
    typedef logic [`CU_REG_W-1:0]   reg_addr_t;  // Register file address
    typedef logic [`CU_DATA_W-1:0]  imm_t;       // Zero-extended immediate

    // Base instruction set
    typedef enum logic [`CU_OPC_W-1:0] {
        OP_LOADI = 4'b0000,
        OP_ADD   = 4'b0001,
        OP_SUB   = 4'b0010,
        OP_AND   = 4'b0011,
        OP_OR    = 4'b0100,
        OP_XOR   = 4'b0101,
        OP_STORE = 4'b0110,
        OP_LOAD  = 4'b0111,
        OP_SHL   = 4'b1000,
        OP_SHR   = 4'b1001,
        OP_MOV   = 4'b1010,
        OP_CMP   = 4'b1011,
        OP_JUMP  = 4'b1100,
        OP_JZ    = 4'b1101,
        OP_JNZ   = 4'b1110,
        OP_NOT   = 4'b1111   // HALT when reg1, reg2 and imm are all zero
    } opcode_t;

    // ALU select as the datapath decodes it; 8 to 11 unused
    typedef enum logic [`CU_ALUOP_W-1:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_NOT    = 4'd5,
        ALU_SHL    = 4'd6,
        ALU_SHR    = 4'd7,
        ALU_PASS_A = 4'd12,  // Operand A through, reg1 side
        ALU_PASS_B = 4'd13   // Operand B through, immediate when selected
    } alu_op_t;

    // Sequencer states
    typedef enum logic [1:0] {
        ST_FETCH   = 2'b00,
        ST_DECODE  = 2'b01,
        ST_EXECUTE = 2'b10,
        ST_HALT    = 2'b11
    } cu_state_t;

endpackage

/* hw/instr_decoder.sv */
/* Purely combinational; outputs follow the instruction input directly,
   so the instruction must stay stable while the sequencer uses them */
`timescale 1ns/100ps
`include "cu_defs.svh"

module instr_decoder (
    input  cu_pkg::instr_t    instruction,
    output cu_pkg::alu_op_t   alu_op,
    output cu_pkg::reg_addr_t reg1_addr,
    output cu_pkg::reg_addr_t reg2_addr,
    output cu_pkg::reg_addr_t reg_dest_addr,
    output cu_pkg::imm_t      immediate,
    output logic              use_immediate,
    output logic              mem_addr_sel,    // Immediate as memory address
    output logic              load_from_mem,   // Writeback from memory, not ALU
    output logic              writes_reg,
    output logic              writes_mem,
    output logic              is_jump,
    output logic              is_branch,       // JZ or JNZ
    output logic              branch_if_zero,  // Branch sense, 1 for JZ
    output logic              is_halt
);

    cu_pkg::opcode_t       opcode;
    cu_pkg::reg_addr_t     reg1;
    cu_pkg::reg_addr_t     reg2;
    logic [`CU_IMM6_W-1:0] imm6;
    cu_pkg::imm_t          imm_ext;
    logic                  fields_zero;

    // Field split
    assign opcode  = cu_pkg::opcode_t'(instruction[`CU_OPC_LSB +: `CU_OPC_W]);
    assign reg1    = instruction[`CU_REG1_LSB +: `CU_REG_W];
    assign reg2    = instruction[`CU_REG2_LSB +: `CU_REG_W];
    assign imm6    = instruction[`CU_IMM6_W-1:0];
    assign imm_ext = {{(`CU_DATA_W-`CU_IMM6_W){1'b0}}, imm6};  // Zero extend

    // Separates HALT from NOT under opcode 1111
    assign fields_zero = (reg1 == '0) && (reg2 == '0) && (imm6 == '0);

    always_comb begin
        // Defaults: plain register-register form, nothing written
        alu_op         = cu_pkg::ALU_ADD;
        reg1_addr      = reg1;
        reg2_addr      = reg2;
        reg_dest_addr  = '0;
        immediate      = imm_ext;
        use_immediate  = 1'b0;
        mem_addr_sel   = 1'b0;
        load_from_mem  = 1'b0;
        writes_reg     = 1'b0;
        writes_mem     = 1'b0;
        is_jump        = 1'b0;
        is_branch      = 1'b0;
        branch_if_zero = 1'b0;
        is_halt        = 1'b0;

        case (opcode)
            cu_pkg::OP_LOADI: begin
                alu_op        = cu_pkg::ALU_PASS_B;  // Immediate straight through
                reg1_addr     = '0;                  // Read R0, operand A unused
                reg_dest_addr = reg1;
                use_immediate = 1'b1;
                writes_reg    = 1'b1;
            end
            cu_pkg::OP_ADD, cu_pkg::OP_SUB, cu_pkg::OP_AND, cu_pkg::OP_OR,
            cu_pkg::OP_XOR, cu_pkg::OP_SHL, cu_pkg::OP_SHR: begin
                // Opcode to ALU select, one to one for these
                case (opcode)
                    cu_pkg::OP_SUB: alu_op = cu_pkg::ALU_SUB;
                    cu_pkg::OP_AND: alu_op = cu_pkg::ALU_AND;
                    cu_pkg::OP_OR:  alu_op = cu_pkg::ALU_OR;
                    cu_pkg::OP_XOR: alu_op = cu_pkg::ALU_XOR;
                    cu_pkg::OP_SHL: alu_op = cu_pkg::ALU_SHL;
                    cu_pkg::OP_SHR: alu_op = cu_pkg::ALU_SHR;
                    default:        alu_op = cu_pkg::ALU_ADD;
                endcase
                reg_dest_addr = reg2;
                writes_reg    = 1'b1;
            end
            cu_pkg::OP_STORE: begin
                alu_op       = cu_pkg::ALU_PASS_A;  // reg1 is the store data
                mem_addr_sel = 1'b1;
                writes_mem   = 1'b1;
            end
            cu_pkg::OP_LOAD: begin
                alu_op        = cu_pkg::ALU_PASS_A;
                reg1_addr     = '0;
                reg_dest_addr = reg1;
                mem_addr_sel  = 1'b1;
                load_from_mem = 1'b1;
                writes_reg    = 1'b1;
            end
            cu_pkg::OP_MOV: begin
                alu_op        = cu_pkg::ALU_PASS_A;  // reg1 source, reg2 dest
                reg_dest_addr = reg2;
                writes_reg    = 1'b1;
            end
            cu_pkg::OP_CMP: begin
                alu_op = cu_pkg::ALU_SUB;  // Flags only
            end
            cu_pkg::OP_JUMP: begin
                is_jump = 1'b1;  // Target taken from the immediate
            end
            cu_pkg::OP_JZ, cu_pkg::OP_JNZ: begin
                // reg1 - 0 so the ALU zero flag reflects reg1
                alu_op         = cu_pkg::ALU_SUB;
                immediate      = '0;
                use_immediate  = 1'b1;
                is_branch      = 1'b1;
                branch_if_zero = (opcode == cu_pkg::OP_JZ);
            end
            cu_pkg::OP_NOT: begin
                if (fields_zero) begin
                    is_halt = 1'b1;
                end else begin
                    alu_op        = cu_pkg::ALU_NOT;
                    reg_dest_addr = reg2;
                    writes_reg    = 1'b1;
                end
            end
            default: ;  // All sixteen codes handled above
        endcase
    end

endmodule

/* hw/control_register.sv */
/* Fields load only on issue and are held until the next issue;
   write strobes are one cycle wide and need no acknowledge */
`timescale 1ns/100ps

module control_register (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue,  // One cycle, from the sequencer in DECODE

    // Decoded fields, combinational
    input  cu_pkg::alu_op_t   dec_alu_op,
    input  cu_pkg::reg_addr_t dec_reg1_addr,
    input  cu_pkg::reg_addr_t dec_reg2_addr,
    input  cu_pkg::reg_addr_t dec_reg_dest_addr,
    input  cu_pkg::imm_t      dec_immediate,
    input  logic              dec_use_immediate,
    input  logic              dec_mem_addr_sel,
    input  logic              dec_load_from_mem,
    input  logic              dec_writes_reg,
    input  logic              dec_writes_mem,

    // Held fields to the datapath
    output cu_pkg::alu_op_t   alu_op,
    output cu_pkg::reg_addr_t reg1_addr,
    output cu_pkg::reg_addr_t reg2_addr,
    output cu_pkg::reg_addr_t reg_dest_addr,
    output cu_pkg::imm_t      immediate,
    output logic              use_immediate,
    output logic              mem_addr_sel,
    output logic              load_from_mem,
    output logic              reg_write_enable,
    output logic              mem_write_enable
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            alu_op        <= cu_pkg::ALU_ADD;
            reg1_addr     <= '0;
            reg2_addr     <= '0;
            reg_dest_addr <= '0;
            immediate     <= '0;
            use_immediate <= 1'b0;
            mem_addr_sel  <= 1'b0;
            load_from_mem <= 1'b0;
        end else if (issue) begin
            // Captured once, stable through EXECUTE for branches
            alu_op        <= dec_alu_op;
            reg1_addr     <= dec_reg1_addr;
            reg2_addr     <= dec_reg2_addr;
            reg_dest_addr <= dec_reg_dest_addr;
            immediate     <= dec_immediate;
            use_immediate <= dec_use_immediate;
            mem_addr_sel  <= dec_mem_addr_sel;
            load_from_mem <= dec_load_from_mem;
        end
    end

    // Strobes, high for the cycle after issue only
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            reg_write_enable <= 1'b0;
            mem_write_enable <= 1'b0;
        end else begin
            reg_write_enable <= issue & dec_writes_reg;
            mem_write_enable <= issue & dec_writes_mem;
        end
    end

    // Issue never repeats back to back, so neither strobe can stretch
    a_reg_we_single: assert property (@(posedge clk) disable iff (rst)
        reg_write_enable |=> !reg_write_enable)
        else $error("reg_write_enable held for two cycles");

    a_mem_we_single: assert property (@(posedge clk) disable iff (rst)
        mem_write_enable |=> !mem_write_enable)
        else $error("mem_write_enable held for two cycles");

endmodule

/* hw/sequencer.sv */
/* Halt is sticky until rst; zero_flag is sampled only at the end of
   EXECUTE for JZ/JNZ and must be valid from the held ALU setup by then */
`timescale 1ns/100ps

module sequencer (
    input  logic clk,
    input  logic rst,
    input  logic zero_flag,       // From the ALU, not registered here
    input  logic is_jump,
    input  logic is_branch,
    input  logic branch_if_zero,
    input  logic is_halt,
    output logic issue,           // Load pulse for the control register
    output logic pc_enable,       // PC increment
    output logic pc_load,         // PC load from target
    output logic halt
);

    cu_pkg::cu_state_t state;
    logic              taken;

    // Branch taken when the flag matches the sense
    assign taken = (zero_flag == branch_if_zero);

    // HALT captures nothing
    assign issue = (state == cu_pkg::ST_DECODE) && !is_halt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= cu_pkg::ST_FETCH;
            pc_enable <= 1'b0;
            pc_load   <= 1'b0;
            halt      <= 1'b0;
        end else begin
            pc_enable <= 1'b0;  // Strobes default low
            pc_load   <= 1'b0;
            case (state)
                cu_pkg::ST_FETCH: begin
                    state <= cu_pkg::ST_DECODE;
                end
                cu_pkg::ST_DECODE: begin
                    if (is_halt) begin
                        halt  <= 1'b1;
                        state <= cu_pkg::ST_HALT;
                    end else if (is_branch) begin
                        state <= cu_pkg::ST_EXECUTE;  // Wait for zero_flag
                    end else begin
                        pc_load   <= is_jump;
                        pc_enable <= !is_jump;
                        state     <= cu_pkg::ST_FETCH;
                    end
                end
                cu_pkg::ST_EXECUTE: begin
                    // Exactly one PC strobe per branch
                    pc_load   <= taken;
                    pc_enable <= !taken;
                    state     <= cu_pkg::ST_FETCH;
                end
                cu_pkg::ST_HALT: begin
                    state <= cu_pkg::ST_HALT;  // Only rst leaves
                end
                default: begin
                    state <= cu_pkg::ST_FETCH;
                end
            endcase
        end
    end

    a_pc_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(pc_enable && pc_load))
        else $error("pc_enable and pc_load high together");

    // Sticky halt, and the FSM parked with it
    a_halt_sticky: assert property (@(posedge clk) disable iff (rst)
        halt |=> halt && (state == cu_pkg::ST_HALT))
        else $error("halt dropped or FSM left ST_HALT");

endmodule

/* hw/control_unit.sv */
/* Sequencing control unit top; the instruction must stay stable from
   FETCH until its completing strobe, and every strobe must be accepted */
`timescale 1ns/100ps

module control_unit (
    input  logic              clk,
    input  logic              rst,
    input  cu_pkg::instr_t    instruction,
    input  logic              zero_flag,
    output logic              pc_enable,
    output logic              pc_load,
    output logic              reg_write_enable,
    output logic              mem_write_enable,
    output cu_pkg::alu_op_t   alu_op,
    output cu_pkg::reg_addr_t reg1_addr,
    output cu_pkg::reg_addr_t reg2_addr,
    output cu_pkg::reg_addr_t reg_dest_addr,
    output cu_pkg::imm_t      immediate,
    output logic              use_immediate,
    output logic              mem_addr_sel,
    output logic              load_from_mem,
    output logic              halt
);

    // Decoder to control register
    cu_pkg::alu_op_t   dec_alu_op;
    cu_pkg::reg_addr_t dec_reg1_addr;
    cu_pkg::reg_addr_t dec_reg2_addr;
    cu_pkg::reg_addr_t dec_reg_dest_addr;
    cu_pkg::imm_t      dec_immediate;
    logic              dec_use_immediate;
    logic              dec_mem_addr_sel;
    logic              dec_load_from_mem;
    logic              dec_writes_reg;
    logic              dec_writes_mem;

    // Decoder to sequencer, and the issue pulse back
    logic              is_jump;
    logic              is_branch;
    logic              branch_if_zero;
    logic              is_halt;
    logic              issue;

    instr_decoder u_decoder (
        .instruction    (instruction),
        .alu_op         (dec_alu_op),
        .reg1_addr      (dec_reg1_addr),
        .reg2_addr      (dec_reg2_addr),
        .reg_dest_addr  (dec_reg_dest_addr),
        .immediate      (dec_immediate),
        .use_immediate  (dec_use_immediate),
        .mem_addr_sel   (dec_mem_addr_sel),
        .load_from_mem  (dec_load_from_mem),
        .writes_reg     (dec_writes_reg),
        .writes_mem     (dec_writes_mem),
        .is_jump        (is_jump),
        .is_branch      (is_branch),
        .branch_if_zero (branch_if_zero),
        .is_halt        (is_halt)
    );

    control_register u_ctrl_reg (
        .clk               (clk),
        .rst               (rst),
        .issue             (issue),
        .dec_alu_op        (dec_alu_op),
        .dec_reg1_addr     (dec_reg1_addr),
        .dec_reg2_addr     (dec_reg2_addr),
        .dec_reg_dest_addr (dec_reg_dest_addr),
        .dec_immediate     (dec_immediate),
        .dec_use_immediate (dec_use_immediate),
        .dec_mem_addr_sel  (dec_mem_addr_sel),
        .dec_load_from_mem (dec_load_from_mem),
        .dec_writes_reg    (dec_writes_reg),
        .dec_writes_mem    (dec_writes_mem),
        .alu_op            (alu_op),
        .reg1_addr         (reg1_addr),
        .reg2_addr         (reg2_addr),
        .reg_dest_addr     (reg_dest_addr),
        .immediate         (immediate),
        .use_immediate     (use_immediate),
        .mem_addr_sel      (mem_addr_sel),
        .load_from_mem     (load_from_mem),
        .reg_write_enable  (reg_write_enable),
        .mem_write_enable  (mem_write_enable)
    );

    sequencer u_sequencer (
        .clk            (clk),
        .rst            (rst),
        .zero_flag      (zero_flag),
        .is_jump        (is_jump),
        .is_branch      (is_branch),
        .branch_if_zero (branch_if_zero),
        .is_halt        (is_halt),
        .issue          (issue),
        .pc_enable      (pc_enable),
        .pc_load        (pc_load),
        .halt           (halt)
    );

endmodule

/* tb/tb_control_unit.sv */
/* Self-checking testbench for control_unit; rows run back to back with no reset
   between them, and the HALT row must stay last */
`timescale 1ns/100ps

module tb_control_unit;

    localparam int MAX_ROWS = 32;
    localparam int C_EN   = 0;  // Completes with pc_enable
    localparam int C_LOAD = 1;  // Completes with pc_load
    localparam int C_HALT = 2;  // Completes with halt rising

    logic clk;
    logic rst;
    cu_pkg::instr_t instruction;
    logic zero_flag;
    logic pc_enable, pc_load, reg_write_enable, mem_write_enable;
    logic use_immediate, mem_addr_sel, load_from_mem, halt;
    cu_pkg::alu_op_t   alu_op;
    cu_pkg::reg_addr_t reg1_addr, reg2_addr, reg_dest_addr;
    cu_pkg::imm_t      immediate;

    // Stimulus and expected-value table
    logic [15:0] t_instr [MAX_ROWS];
    logic        t_zf    [MAX_ROWS];
    int          t_comp  [MAX_ROWS];
    logic [3:0]  t_alu   [MAX_ROWS];
    logic [2:0]  t_dest  [MAX_ROWS];
    logic [2:0]  t_reg1  [MAX_ROWS];
    logic [2:0]  t_reg2  [MAX_ROWS];  // reg2 field, passed through unchanged
    logic [7:0]  t_imm   [MAX_ROWS];
    logic        t_useimm [MAX_ROWS];
    logic        t_lfm   [MAX_ROWS];
    logic        t_mas   [MAX_ROWS];
    logic        t_rwe   [MAX_ROWS];
    logic        t_mwe   [MAX_ROWS];
    int          num_rows;

    int          errors;
    int          cycles;
    int          cycle_limit;
    int unsigned seed;
    logic [2:0]  r1, r2;   // Random register fields of the current row
    logic [5:0]  im;       // Random immediate of the current row

    control_unit uut (
        .clk(clk), .rst(rst), .instruction(instruction), .zero_flag(zero_flag),
        .pc_enable(pc_enable), .pc_load(pc_load),
        .reg_write_enable(reg_write_enable), .mem_write_enable(mem_write_enable),
        .alu_op(alu_op), .reg1_addr(reg1_addr), .reg2_addr(reg2_addr),
        .reg_dest_addr(reg_dest_addr), .immediate(immediate),
        .use_immediate(use_immediate), .mem_addr_sel(mem_addr_sel),
        .load_from_mem(load_from_mem), .halt(halt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // Watchdog, limit set once the table is known
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: no completion strobe within %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("ERR %s got=%h exp=%h at %0t", name, got, exp, $time);
            errors = errors + 1;
        end
    endtask

    task automatic pick_fields();
        r1 = 3'($urandom);
        r2 = 3'($urandom);
        im = 6'($urandom);
    endtask

    task automatic add_row(input logic [3:0] opc, input logic zf, input int comp,
                           input logic [3:0] alu, input logic [2:0] dest,
                           input logic [2:0] reg1, input logic [7:0] imm,
                           input logic useimm, input logic lfm, input logic mas,
                           input logic rwe, input logic mwe);
        t_instr[num_rows]  = {opc, r1, r2, im};
        t_zf[num_rows]     = zf;
        t_comp[num_rows]   = comp;
        t_alu[num_rows]    = alu;
        t_dest[num_rows]   = dest;
        t_reg1[num_rows]   = reg1;
        t_reg2[num_rows]   = r2;
        t_imm[num_rows]    = imm;
        t_useimm[num_rows] = useimm;
        t_lfm[num_rows]    = lfm;
        t_mas[num_rows]    = mas;
        t_rwe[num_rows]    = rwe;
        t_mwe[num_rows]    = mwe;
        num_rows = num_rows + 1;
    endtask

    task automatic strobes_low(input string when_txt);
        check({"pc_enable ", when_txt}, 16'(pc_enable), 16'h0);
        check({"pc_load ", when_txt}, 16'(pc_load), 16'h0);
        check({"reg_write_enable ", when_txt}, 16'(reg_write_enable), 16'h0);
        check({"mem_write_enable ", when_txt}, 16'(mem_write_enable), 16'h0);
    endtask

    initial begin
        int i;
        logic done;
        seed = $urandom(32'h70fd);
        errors = 0;
        cycles = 0;
        cycle_limit = 1000;
        num_rows = 0;
        rst = 1'b1;
        instruction = '0;
        zero_flag = 1'b0;

        // ALU forms write reg2
        pick_fields();
        add_row(4'h1, 0, C_EN, 4'd0, r2, r1, {2'b0, im}, 0, 0, 0, 1, 0);
        pick_fields();
        add_row(4'h2, 0, C_EN, 4'd1, r2, r1, {2'b0, im}, 0, 0, 0, 1, 0);
        pick_fields();
        add_row(4'h3, 0, C_EN, 4'd2, r2, r1, {2'b0, im}, 0, 0, 0, 1, 0);
        pick_fields();
        add_row(4'h4, 0, C_EN, 4'd3, r2, r1, {2'b0, im}, 0, 0, 0, 1, 0);
        pick_fields();
        add_row(4'h5, 0, C_EN, 4'd4, r2, r1, {2'b0, im}, 0, 0, 0, 1, 0);
        pick_fields();
        add_row(4'h8, 0, C_EN, 4'd6, r2, r1, {2'b0, im}, 0, 0, 0, 1, 0);
        pick_fields();
        add_row(4'h9, 0, C_EN, 4'd7, r2, r1, {2'b0, im}, 0, 0, 0, 1, 0);
        pick_fields();
        add_row(4'hA, 0, C_EN, 4'd12, r2, r1, {2'b0, im}, 0, 0, 0, 1, 0);
        pick_fields();
        r2 = r2 | 3'd1;  // Nonzero so it stays NOT, not HALT
        add_row(4'hF, 0, C_EN, 4'd5, r2, r1, {2'b0, im}, 0, 0, 0, 1, 0);
        pick_fields();
        add_row(4'hB, 0, C_EN, 4'd1, 3'd0, r1, {2'b0, im}, 0, 0, 0, 0, 0);
        // Immediate and memory forms
        pick_fields();
        add_row(4'h0, 0, C_EN, 4'd13, r1, 3'd0, {2'b0, im}, 1, 0, 0, 1, 0);
        pick_fields();
        add_row(4'h7, 0, C_EN, 4'd12, r1, 3'd0, {2'b0, im}, 0, 1, 1, 1, 0);
        pick_fields();
        add_row(4'h6, 0, C_EN, 4'd12, 3'd0, r1, {2'b0, im}, 0, 0, 1, 0, 1);
        // Jump and both branch senses, taken and not taken
        pick_fields();
        add_row(4'hC, 0, C_LOAD, 4'd0, 3'd0, r1, {2'b0, im}, 0, 0, 0, 0, 0);
        pick_fields();
        add_row(4'hD, 1, C_LOAD, 4'd1, 3'd0, r1, 8'h00, 1, 0, 0, 0, 0);
        pick_fields();
        add_row(4'hD, 0, C_EN, 4'd1, 3'd0, r1, 8'h00, 1, 0, 0, 0, 0);
        pick_fields();
        add_row(4'hE, 0, C_LOAD, 4'd1, 3'd0, r1, 8'h00, 1, 0, 0, 0, 0);
        pick_fields();
        add_row(4'hE, 1, C_EN, 4'd1, 3'd0, r1, 8'h00, 1, 0, 0, 0, 0);
        // HALT last; fields keep the previous row's values
        r1 = 3'd0;
        r2 = 3'd0;
        im = 6'd0;
        add_row(4'hF, 0, C_HALT, 4'd1, 3'd0, t_reg1[num_rows-1], 8'h00, 1, 0, 0, 0, 0);
        t_reg2[num_rows-1] = t_reg2[num_rows-2];  // Held from the last branch
        cycle_limit = num_rows * 4 + 20;

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        strobes_low("after reset");
        check("halt after reset", 16'(halt), 16'h0);
        check("alu_op after reset", 16'(alu_op), 16'h0);
        check("reg_dest_addr after reset", 16'(reg_dest_addr), 16'h0);
        check("reg1_addr after reset", 16'(reg1_addr), 16'h0);
        check("reg2_addr after reset", 16'(reg2_addr), 16'h0);
        check("immediate after reset", 16'(immediate), 16'h0);
        check("use_immediate after reset", 16'(use_immediate), 16'h0);
        check("load_from_mem after reset", 16'(load_from_mem), 16'h0);
        check("mem_addr_sel after reset", 16'(mem_addr_sel), 16'h0);

        for (i = 0; i < num_rows; i++) begin
            @(posedge clk);
            instruction <= t_instr[i];
            zero_flag   <= t_zf[i];
            @(negedge clk);
            if (i > 0) strobes_low("one cycle after completion");  // Single-cycle strobes
            done = 1'b0;
            while (!done) begin
                if (pc_enable || pc_load || halt) done = 1'b1;
                else @(negedge clk);
            end
            check("pc_enable", 16'(pc_enable), 16'(t_comp[i] == C_EN));
            check("pc_load", 16'(pc_load), 16'(t_comp[i] == C_LOAD));
            check("halt", 16'(halt), 16'(t_comp[i] == C_HALT));
            check("alu_op", 16'(alu_op), 16'(t_alu[i]));
            check("reg_dest_addr", 16'(reg_dest_addr), 16'(t_dest[i]));
            check("reg1_addr", 16'(reg1_addr), 16'(t_reg1[i]));
            check("reg2_addr", 16'(reg2_addr), 16'(t_reg2[i]));
            check("immediate", 16'(immediate), 16'(t_imm[i]));
            check("use_immediate", 16'(use_immediate), 16'(t_useimm[i]));
            check("load_from_mem", 16'(load_from_mem), 16'(t_lfm[i]));
            check("mem_addr_sel", 16'(mem_addr_sel), 16'(t_mas[i]));
            check("reg_write_enable", 16'(reg_write_enable), 16'(t_rwe[i]));
            check("mem_write_enable", 16'(mem_write_enable), 16'(t_mwe[i]));
        end

        // After HALT, further instructions must not wake the FSM
        @(posedge clk);
        instruction <= t_instr[0];
        repeat (6) begin
            @(negedge clk);
            strobes_low("while halted");
            check("halt while halted", 16'(halt), 16'h1);
        end

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* control_unit.f */
+incdir+hw
hw/cu_pkg.sv
hw/instr_decoder.sv
hw/control_register.sv
hw/sequencer.sv
hw/control_unit.sv
tb/tb_control_unit.sv

/* Makefile */
# Verilator flow for the control unit testbench
VERILATOR ?= verilator
TOP       ?= tb_control_unit
FILELIST  ?= control_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf $(OBJ_DIR)
